/* compile.f */
+incdir+.
pad_ctrl_pkg.sv
pad_apb_regs.sv
pad_in_sync.sv
pad_mux.sv
pad_ctrl_top.sv
tb_pad_ctrl.sv

/* Bender.yml */
package:
  name: pad_ctrl

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - pad_ctrl_pkg.sv
      - pad_apb_regs.sv
      - pad_in_sync.sv
      - pad_mux.sv
      - pad_ctrl_top.sv
  - target: test
    files:
      - tb_pad_ctrl.sv

/* tb_pad_ctrl.sv */
/*
 * Pad controller testbench
 * Acts as APB master into the pad controller, drives random pad sources
 * and pad inputs, and checks readback, pad routing, synchronised GPIO
 * input and bus errors against a register model
 */

`timescale 1ns/1ps

`include "pad_ctrl_macros.svh"

module tb_pad_ctrl;

  localparam int CLK_HALF    = 20;
  localparam int N_XFERS     = 142;
  localparam int WATCHDOG_NS = (N_XFERS * 3 + 200) * 2 * CLK_HALF;

  logic                                    ref_clk_i;
  logic                                    rst_i;
  pad_ctrl_pkg::apb_req_t                  apb_req;
  pad_ctrl_pkg::apb_rsp_t                  apb_rsp;
  pad_ctrl_pkg::pad_src_t                  perio_src;
  pad_ctrl_pkg::pad_src_t                  fpgaio_src;
  logic [`PAD_N_IO-1:0]                    perio_in;
  logic [`PAD_N_IO-1:0]                    fpgaio_in;
  logic [`PAD_N_IO-1:0]                    io_in;
  logic [`PAD_N_IO-1:0]                    io_out;
  logic [`PAD_N_IO-1:0]                    io_oe;
  logic [`PAD_N_IO-1:0][`PAD_CFG_BITS-1:0] pad_cfg;

  // Register model
  logic [15:0] sel_m;
  logic [15:0] cfg_m;
  logic [7:0]  out_m;
  logic [7:0]  oe_m;
  logic        exp_err;

  int seed = 32'h787c;
  int errors;
  int checks;
  int tests;

  pad_ctrl_top pad_ctrl_top_i (
    .ref_clk_i    (ref_clk_i),
    .rst_i        (rst_i),
    .apb_req_i    (apb_req),
    .apb_rsp_o    (apb_rsp),
    .perio_src_i  (perio_src),
    .fpgaio_src_i (fpgaio_src),
    .perio_in_o   (perio_in),
    .fpgaio_in_o  (fpgaio_in),
    .io_in_i      (io_in),
    .io_out_o     (io_out),
    .io_oe_o      (io_oe),
    .pad_cfg_o    (pad_cfg)
  );

  always #(CLK_HALF) ref_clk_i = ~ref_clk_i;

  a_pready: assert property (@(posedge ref_clk_i) disable iff (rst_i)
    (apb_req.psel && apb_req.penable) |-> apb_rsp.pready)
    else begin
      errors++;
      $display("error %0t: pready expected 1 got %b", $time, $sampled(apb_rsp.pready));
    end

  a_pslverr: assert property (@(posedge ref_clk_i) disable iff (rst_i)
    (apb_req.psel && apb_req.penable) |-> (apb_rsp.pslverr == exp_err))
    else begin
      errors++;
      $display("error %0t: pslverr expected %b got %b", $time,
               $sampled(exp_err), $sampled(apb_rsp.pslverr));
    end

  a_idle_quiet: assert property (@(posedge ref_clk_i) disable iff (rst_i)
    !(apb_req.psel && apb_req.penable) |-> (!apb_rsp.pready && !apb_rsp.pslverr))
    else begin
      errors++;
      $display("pready or pslverr high outside an access cycle at %0t", $time);
    end

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("error %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic report_test(input string name);
    tests++;
    $display("test %0d %s finished, %0d errors so far", tests, name, errors);
  endtask

  task automatic model_write(input logic [11:0] addr, input logic [31:0] data);
    case (addr)
      pad_ctrl_pkg::REG_PADMUX:   sel_m = data[15:0];
      pad_ctrl_pkg::REG_PADCFG:   cfg_m = data[15:0];
      pad_ctrl_pkg::REG_GPIO_OUT: out_m = data[7:0];
      pad_ctrl_pkg::REG_GPIO_OE:  oe_m  = data[7:0];
      default: ;
    endcase
  endtask

  function automatic logic [31:0] model_read(input logic [11:0] addr);
    case (addr)
      pad_ctrl_pkg::REG_PADMUX:   return {16'h0, sel_m};
      pad_ctrl_pkg::REG_PADCFG:   return {16'h0, cfg_m};
      pad_ctrl_pkg::REG_GPIO_OUT: return {24'h0, out_m};
      pad_ctrl_pkg::REG_GPIO_OE:  return {24'h0, oe_m};
      default:                    return '0;
    endcase
  endfunction

  // Setup, access, then one idle edge where a write lands
  task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata);
    logic bad;
    bad = !(addr inside {pad_ctrl_pkg::REG_PADMUX, pad_ctrl_pkg::REG_PADCFG,
                         pad_ctrl_pkg::REG_GPIO_OUT, pad_ctrl_pkg::REG_GPIO_OE,
                         pad_ctrl_pkg::REG_GPIO_IN})
          || (wr && addr == pad_ctrl_pkg::REG_GPIO_IN);
    @(posedge ref_clk_i);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= wr;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= wr ? wdata : '0;
    exp_err         <= bad;
    @(posedge ref_clk_i);
    apb_req.penable <= 1'b1;
    @(negedge ref_clk_i);
    rdata = apb_rsp.prdata;
    @(posedge ref_clk_i);
    apb_req <= '0;
    exp_err <= 1'b0;
    if (wr && !bad) begin
      model_write(addr, wdata);
    end
  endtask

  task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    apb_xfer(1'b1, addr, data, unused);
  endtask

  task automatic read_check(input logic [11:0] addr, input logic [31:0] exp);
    logic [31:0] rd;
    apb_xfer(1'b0, addr, '0, rd);
    check_eq($sformatf("prdata[%h]", addr), exp, rd);
  endtask

  // Pad routing against the model, mid-cycle
  always @(negedge ref_clk_i) begin : route_check
    logic [7:0] exp_out;
    logic [7:0] exp_oe;
    logic [7:0] exp_pin;
    logic [7:0] exp_fin;
    if (!rst_i) begin
      exp_out = '0;
      exp_oe  = '0;
      exp_pin = '0;
      exp_fin = '0;
      for (int i = 0; i < `PAD_N_IO; i++) begin
        case (pad_ctrl_pkg::pad_sel_e'(sel_m[2*i +: 2]))
          pad_ctrl_pkg::SEL_GPIO: begin
            exp_out[i] = out_m[i];
            exp_oe[i]  = oe_m[i];
          end
          pad_ctrl_pkg::SEL_PERIO: begin
            exp_out[i] = perio_src.out[i];
            exp_oe[i]  = perio_src.oe[i];
            exp_pin[i] = io_in[i];
          end
          pad_ctrl_pkg::SEL_FPGAIO: begin
            exp_out[i] = fpgaio_src.out[i];
            exp_oe[i]  = fpgaio_src.oe[i];
            exp_fin[i] = io_in[i];
          end
          default: ;
        endcase
      end
      check_eq("io_out_o", exp_out, io_out);
      check_eq("io_oe_o", exp_oe, io_oe);
      check_eq("perio_in_o", exp_pin, perio_in);
      check_eq("fpgaio_in_o", exp_fin, fpgaio_in);
      check_eq("pad_cfg_o", cfg_m, pad_cfg);
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, run did not finish", WATCHDOG_NS);
    $display("Errors found");
    $finish;
  end

  initial begin
    logic [31:0] wd;
    logic [31:0] rd;
    logic [7:0]  gin;
    logic [11:0] bad_addr [4];
    bad_addr   = '{12'h014, 12'h020, 12'hFFC, 12'h002};
    ref_clk_i  = 1'b0;
    rst_i      = 1'b1;
    apb_req    = '0;
    perio_src  = '0;
    fpgaio_src = '0;
    io_in      = '0;
    exp_err    = 1'b0;
    sel_m      = '0;
    cfg_m      = '0;
    out_m      = '0;
    oe_m       = '0;
    errors     = 0;
    checks     = 0;
    tests      = 0;
    repeat (8) @(posedge ref_clk_i);
    rst_i <= 1'b0;

    @(negedge ref_clk_i);
    check_eq("io_oe_o", '0, io_oe);
    check_eq("pad_cfg_o", '0, pad_cfg);
    for (int k = 0; k < 4; k++) begin
      read_check(12'(4 * k), '0);
    end
    report_test("reset state");

    for (int n = 0; n < 8; n++) begin
      for (int k = 0; k < 4; k++) begin
        wd = $random(seed);
        apb_write(12'(4 * k), wd);
        read_check(12'(4 * k), model_read(12'(4 * k)));
      end
    end
    report_test("register readback");

    for (int n = 0; n < 12; n++) begin
      @(posedge ref_clk_i);
      perio_src  <= 16'($random(seed));
      fpgaio_src <= 16'($random(seed));
      apb_write(pad_ctrl_pkg::REG_PADMUX, $random(seed));
      apb_write(pad_ctrl_pkg::REG_GPIO_OUT, $random(seed));
      apb_write(pad_ctrl_pkg::REG_GPIO_OE, $random(seed));
    end
    report_test("output routing");

    for (int n = 0; n < 8; n++) begin
      @(posedge ref_clk_i);
      io_in <= 8'($random(seed));
      apb_write(pad_ctrl_pkg::REG_PADMUX, $random(seed));
      repeat (2) @(posedge ref_clk_i);
    end
    report_test("input routing");

    // Read just after a change, then again while the next change lands
    for (int n = 0; n < 8; n++) begin
      @(posedge ref_clk_i);
      wd = $random(seed);
      gin = io_in ^ (wd[7:0] | 8'h01);
      io_in <= gin;
      read_check(pad_ctrl_pkg::REG_GPIO_IN, {24'h0, gin});
      wd = $random(seed);
      fork
        read_check(pad_ctrl_pkg::REG_GPIO_IN, {24'h0, gin});
        begin
          @(posedge ref_clk_i);
          io_in <= gin ^ (wd[7:0] | 8'h01);
        end
      join
    end
    report_test("synchronised gpio input");

    for (int k = 0; k < 4; k++) begin
      apb_write(bad_addr[k], $random(seed));
      apb_xfer(1'b0, bad_addr[k], '0, rd);
    end
    apb_write(pad_ctrl_pkg::REG_GPIO_IN, $random(seed));
    apb_write(pad_ctrl_pkg::REG_GPIO_IN, $random(seed));
    for (int k = 0; k < 4; k++) begin
      read_check(12'(4 * k), model_read(12'(4 * k)));
    end
    report_test("bus errors");

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* pad_ctrl_top.sv */
/*
 * Pad controller top
 * APB register bank, pad input synchroniser and pad mux for a set
 * of pads shared by GPIO, peripherals and the FPGA fabric
 */

`timescale 1ns/1ps

`include "pad_ctrl_macros.svh"

module pad_ctrl_top (
  input  logic                                     ref_clk_i,
  input  logic                                     rst_i,

  input  pad_ctrl_pkg::apb_req_t                   apb_req_i,
  output pad_ctrl_pkg::apb_rsp_t                   apb_rsp_o,

  input  pad_ctrl_pkg::pad_src_t                   perio_src_i,
  input  pad_ctrl_pkg::pad_src_t                   fpgaio_src_i,
  output logic [`PAD_N_IO-1:0]                     perio_in_o,
  output logic [`PAD_N_IO-1:0]                     fpgaio_in_o,

  input  logic [`PAD_N_IO-1:0]                     io_in_i,
  output logic [`PAD_N_IO-1:0]                     io_out_o,
  output logic [`PAD_N_IO-1:0]                     io_oe_o,
  output logic [`PAD_N_IO-1:0][`PAD_CFG_BITS-1:0]  pad_cfg_o
);

  pad_ctrl_pkg::pad_sel_t pad_sel;
  pad_ctrl_pkg::pad_src_t gpio_src;
  logic [`PAD_N_IO-1:0]   gpio_in_sync;

  pad_apb_regs pad_apb_regs_i (
    .ref_clk_i  (ref_clk_i),
    .rst_i      (rst_i),
    .apb_req_i  (apb_req_i),
    .apb_rsp_o  (apb_rsp_o),
    .gpio_in_i  (gpio_in_sync),
    .pad_sel_o  (pad_sel),
    .gpio_src_o (gpio_src),
    .pad_cfg_o  (pad_cfg_o)
  );

  pad_in_sync pad_in_sync_i (
    .ref_clk_i (ref_clk_i),
    .rst_i     (rst_i),
    .async_i   (io_in_i),
    .sync_o    (gpio_in_sync)
  );

  pad_mux pad_mux_i (
    .pad_sel_i    (pad_sel),
    .perio_src_i  (perio_src_i),
    .gpio_src_i   (gpio_src),
    .fpgaio_src_i (fpgaio_src_i),
    .io_in_i      (io_in_i),
    .io_out_o     (io_out_o),
    .io_oe_o      (io_oe_o),
    .perio_in_o   (perio_in_o),
    .fpgaio_in_o  (fpgaio_in_o)
  );

endmodule

/* pad_mux.sv */
/*
 * Pad mux
 * Routes each pad's output and enable from the GPIO, peripheral or
 * FPGA source named by its select, and hands the pad input back only
 * to the peripheral or FPGA side that owns the pad
 */

`timescale 1ns/1ps

`include "pad_ctrl_macros.svh"

module pad_mux (
  input  pad_ctrl_pkg::pad_sel_t pad_sel_i,
  input  pad_ctrl_pkg::pad_src_t perio_src_i,
  input  pad_ctrl_pkg::pad_src_t gpio_src_i,
  input  pad_ctrl_pkg::pad_src_t fpgaio_src_i,
  input  logic [`PAD_N_IO-1:0]   io_in_i,
  output logic [`PAD_N_IO-1:0]   io_out_o,
  output logic [`PAD_N_IO-1:0]   io_oe_o,
  output logic [`PAD_N_IO-1:0]   perio_in_o,
  output logic [`PAD_N_IO-1:0]   fpgaio_in_o
);

  always_comb begin
    io_out_o    = '0;
    io_oe_o     = '0;
    perio_in_o  = '0;
    fpgaio_in_o = '0;
    for (int i = 0; i < `PAD_N_IO; i++) begin
      case (pad_sel_i[i])
        pad_ctrl_pkg::SEL_GPIO: begin
          io_out_o[i] = gpio_src_i.out[i];
          io_oe_o[i]  = gpio_src_i.oe[i];
        end
        pad_ctrl_pkg::SEL_PERIO: begin
          io_out_o[i]   = perio_src_i.out[i];
          io_oe_o[i]    = perio_src_i.oe[i];
          perio_in_o[i] = io_in_i[i];
        end
        pad_ctrl_pkg::SEL_FPGAIO: begin
          io_out_o[i]    = fpgaio_src_i.out[i];
          io_oe_o[i]     = fpgaio_src_i.oe[i];
          fpgaio_in_o[i] = io_in_i[i];
        end
        // Pad switched off, stays undriven
        default: begin
          io_out_o[i] = 1'b0;
          io_oe_o[i]  = 1'b0;
        end
      endcase
    end
  end

endmodule

/* pad_in_sync.sv */
/*
 * Pad input synchroniser
 * Flop chain per pad that moves the asynchronous pad inputs into
 * the ref_clk domain before software samples them
 */

`timescale 1ns/1ps

`include "pad_ctrl_macros.svh"

module pad_in_sync (
  input  logic                 ref_clk_i,
  input  logic                 rst_i,
  input  logic [`PAD_N_IO-1:0] async_i,
  output logic [`PAD_N_IO-1:0] sync_o
);

  localparam int STAGES = `PAD_SYNC_STAGES;

  logic [STAGES-1:0][`PAD_N_IO-1:0] sync_q;

  always_ff @(posedge ref_clk_i) begin
    if (rst_i) begin
      sync_q <= '0;
    end else begin
      sync_q[0] <= async_i;
      for (int s = 1; s < STAGES; s++) begin
        sync_q[s] <= sync_q[s-1];
      end
    end
  end

  // Last stage is the metastability-free copy
  assign sync_o = sync_q[STAGES-1];

endmodule

/* pad_apb_regs.sv */
/*
 * Pad controller register bank
 * Zero-wait APB slave holding the pad mux selects, the pad configuration
 * and the GPIO output and output-enable registers. GPIO input reads come
 * from the synchronised pad inputs. Unmapped offsets and writes to the
 * GPIO input register answer with pslverr.
 */

`timescale 1ns/1ps

`include "pad_ctrl_macros.svh"

module pad_apb_regs (
  input  logic                                     ref_clk_i,
  input  logic                                     rst_i,

  input  pad_ctrl_pkg::apb_req_t                   apb_req_i,
  output pad_ctrl_pkg::apb_rsp_t                   apb_rsp_o,

  input  logic [`PAD_N_IO-1:0]                     gpio_in_i,

  output pad_ctrl_pkg::pad_sel_t                   pad_sel_o,
  output pad_ctrl_pkg::pad_src_t                   gpio_src_o,
  output logic [`PAD_N_IO-1:0][`PAD_CFG_BITS-1:0]  pad_cfg_o
);

  localparam int SEL_W = `PAD_N_IO * `PAD_SEL_BITS;
  localparam int CFG_W = `PAD_N_IO * `PAD_CFG_BITS;

  pad_ctrl_pkg::pad_sel_t                  pad_sel_q;
  pad_ctrl_pkg::pad_src_t                  gpio_q;
  logic [`PAD_N_IO-1:0][`PAD_CFG_BITS-1:0] pad_cfg_q;

  logic                   access;
  logic                   addr_ok;
  logic                   ro_write;
  logic                   err;
  logic                   wr_en;
  logic [`PAD_APB_DW-1:0] rdata;

  assign access = apb_req_i.psel & apb_req_i.penable;

  // Address decode and read mux
  always_comb begin
    addr_ok = 1'b1;
    rdata   = '0;
    case (apb_req_i.paddr)
      pad_ctrl_pkg::REG_PADMUX:   rdata[SEL_W-1:0]     = pad_sel_q;
      pad_ctrl_pkg::REG_PADCFG:   rdata[CFG_W-1:0]     = pad_cfg_q;
      pad_ctrl_pkg::REG_GPIO_OUT: rdata[`PAD_N_IO-1:0] = gpio_q.out;
      pad_ctrl_pkg::REG_GPIO_OE:  rdata[`PAD_N_IO-1:0] = gpio_q.oe;
      pad_ctrl_pkg::REG_GPIO_IN:  rdata[`PAD_N_IO-1:0] = gpio_in_i;
      default:                    addr_ok              = 1'b0;
    endcase
  end

  assign ro_write = apb_req_i.pwrite && (apb_req_i.paddr == pad_ctrl_pkg::REG_GPIO_IN);
  assign err      = access & (~addr_ok | ro_write);
  assign wr_en    = access & apb_req_i.pwrite & ~err;

  // Slave never stalls
  assign apb_rsp_o.pready  = access;
  assign apb_rsp_o.pslverr = err;
  assign apb_rsp_o.prdata  = (access && !apb_req_i.pwrite && !err) ? rdata : '0;

  always_ff @(posedge ref_clk_i) begin
    if (rst_i) begin
      pad_sel_q <= pad_ctrl_pkg::pad_sel_t'({`PAD_N_IO{pad_ctrl_pkg::SEL_GPIO}});
      pad_cfg_q <= '0;
      gpio_q    <= '0;
    end else if (wr_en) begin
      case (apb_req_i.paddr)
        pad_ctrl_pkg::REG_PADMUX: begin
          pad_sel_q <= pad_ctrl_pkg::pad_sel_t'(apb_req_i.pwdata[SEL_W-1:0]);
        end
        pad_ctrl_pkg::REG_PADCFG: begin
          pad_cfg_q <= apb_req_i.pwdata[CFG_W-1:0];
        end
        pad_ctrl_pkg::REG_GPIO_OUT: begin
          gpio_q.out <= apb_req_i.pwdata[`PAD_N_IO-1:0];
        end
        pad_ctrl_pkg::REG_GPIO_OE: begin
          gpio_q.oe <= apb_req_i.pwdata[`PAD_N_IO-1:0];
        end
        default: begin
          gpio_q <= gpio_q;
        end
      endcase
    end
  end

  assign pad_sel_o  = pad_sel_q;
  assign gpio_src_o = gpio_q;
  assign pad_cfg_o  = pad_cfg_q;

  // APB protocol checks
  a_access_after_setup: assert property (
    @(posedge ref_clk_i) disable iff (rst_i)
    (apb_req_i.psel && apb_req_i.penable) |-> $past(apb_req_i.psel && !apb_req_i.penable)
  ) else $error("access cycle without a setup cycle");

  a_paddr_stable: assert property (
    @(posedge ref_clk_i) disable iff (rst_i)
    (apb_req_i.psel && !apb_req_i.penable) ##1 (apb_req_i.psel && apb_req_i.penable)
      |-> $stable(apb_req_i.paddr)
  ) else $error("paddr changed between setup and access");

endmodule

/* pad_ctrl_pkg.sv */
/*
 * Pad controller types
 * Mux select encoding, register map and the bundles that carry
 * APB traffic and per-source pad drive
 */

`include "pad_ctrl_macros.svh"

package pad_ctrl_pkg;

  typedef enum logic [`PAD_SEL_BITS-1:0] {
    SEL_GPIO   = 2'd0,
    SEL_PERIO  = 2'd1,
    SEL_FPGAIO = 2'd2,
    SEL_OFF    = 2'd3
  } pad_sel_e;

  // Word offsets
  typedef enum logic [`PAD_APB_AW-1:0] {
    REG_PADMUX   = 12'h000,
    REG_PADCFG   = 12'h004,
    REG_GPIO_OUT = 12'h008,
    REG_GPIO_OE  = 12'h00C,
    REG_GPIO_IN  = 12'h010
  } reg_addr_e;

  typedef struct packed {
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`PAD_APB_AW-1:0] paddr;
    logic [`PAD_APB_DW-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic                   pready;
    logic                   pslverr;
    logic [`PAD_APB_DW-1:0] prdata;
  } apb_rsp_t;

  typedef struct packed {
    logic [`PAD_N_IO-1:0] out;
    logic [`PAD_N_IO-1:0] oe;
  } pad_src_t;

  typedef pad_sel_e [`PAD_N_IO-1:0] pad_sel_t;

endpackage

/* pad_ctrl_macros.svh */
/*
 * Pad controller sizing
 * Pad count, select and config field widths, APB bus widths and
 * the depth of the pad input synchroniser
 */

`ifndef PAD_CTRL_MACROS_SVH
`define PAD_CTRL_MACROS_SVH

`define PAD_N_IO        8
`define PAD_SEL_BITS    2
`define PAD_CFG_BITS    2

`define PAD_APB_AW      12
`define PAD_APB_DW      32

`define PAD_SYNC_STAGES 2

`endif
